// ==== verilog/vlane_pkg.sv ====
`default_nettype none

package vlane_pkg;

    ////////////////////////////////////////
    // Sizes

    // One driver per write port
    localparam int W_PORTS_NUM = 4;

    // Two read ports per driver
    localparam int R_PORTS_NUM = 2 * W_PORTS_NUM;

    localparam int VLANE_NUM = 4;

    localparam int MEM_DEPTH = 512;     // Words per lane bank

    localparam int ADDR_W = $clog2(MEM_DEPTH);
    localparam int DRV_SEL_W = $clog2(W_PORTS_NUM);

    localparam int WORD_W = 32;
    localparam int BYTES_NUM = WORD_W / 8;

    ////////////////////////////////////////
    // Vector types

    typedef logic [ADDR_W - 1 : 0] vrf_addr_t;      // Bank word address

    typedef logic [WORD_W - 1 : 0] word_t;

    typedef logic [BYTES_NUM - 1 : 0] bwen_t;       // One bit per byte lane

    // Index of an instruction driver
    typedef logic [DRV_SEL_W - 1 : 0] drv_sel_t;

endpackage

`default_nettype wire

// ==== verilog/lane_vrf_if.sv ====
`default_nettype none

interface lane_vrf_if
    import vlane_pkg::*;
();

    // Read side, one entry per lane read port
    logic [R_PORTS_NUM - 1 : 0] ren;
    vrf_addr_t [R_PORTS_NUM - 1 : 0] raddr;

    // Write side, one entry per driver
    vrf_addr_t [W_PORTS_NUM - 1 : 0] waddr;
    bwen_t [W_PORTS_NUM - 1 : 0] bwen;      // Zero means no write
    word_t [W_PORTS_NUM - 1 : 0] wdata;

    // Interconnect drives everything
    modport ic (
        output ren,
        output raddr,
        output waddr,
        output bwen,
        output wdata
    );

    // Register-file bank of one lane
    modport lane (
        input ren,
        input raddr,
        input waddr,
        input bwen,
        input wdata
    );

endinterface

`default_nettype wire

// ==== verilog/read_port_allocator.sv ====
`default_nettype none

module read_port_allocator
    import vlane_pkg::*;
(
    input wire logic clk_i,
    input wire logic rst_i,

    input wire logic [W_PORTS_NUM - 1 : 0] vrf_ren_i,
    input wire logic [W_PORTS_NUM - 1 : 0] vrf_op3_ren_i,

    output drv_sel_t [R_PORTS_NUM - 1 : 0] read_port_allocation_o,
    output logic [R_PORTS_NUM - 1 : 0] primary_read_data_o
);

    logic [W_PORTS_NUM - 1 : 0] op3_req;
    drv_sel_t [R_PORTS_NUM - 1 : 0] alloc_next;
    logic [R_PORTS_NUM - 1 : 0] primary_next;

    // Only active drivers may borrow a port
    assign op3_req = vrf_ren_i & vrf_op3_ren_i;

    ////////////////////////////////////////
    // Single ascending pass

    always_comb begin
        int cand_ptr;
        logic found;

        alloc_next = '0;
        primary_next = '1;
        cand_ptr = 0;
        found = 1'b0;

        for (int k = 0; k < W_PORTS_NUM; k++) begin
            if (!vrf_ren_i[k]) begin
                found = 1'b0;
                // Next unserved requester, if any is left
                for (int c = 0; c < W_PORTS_NUM; c++) begin
                    if (!found && c >= cand_ptr && op3_req[c]) begin
                        found = 1'b1;
                        alloc_next[2 * k] = drv_sel_t'(c);
                        primary_next[2 * k] = 1'b0;   // Even port turns secondary
                        cand_ptr = c + 1;
                    end
                end
            end
        end
    end

    // Same edge as the interconnect input register
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            read_port_allocation_o <= '0;
            primary_read_data_o <= '1;
        end else begin
            read_port_allocation_o <= alloc_next;
            primary_read_data_o <= primary_next;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/driver_vlane_interconnect.sv ====
`default_nettype none

module driver_vlane_interconnect
    import vlane_pkg::*;
(
    input wire logic clk_i,
    input wire logic rst_i,

    // Driver requests
    input wire logic [W_PORTS_NUM - 1 : 0] vrf_ren_i,
    input wire logic [W_PORTS_NUM - 1 : 0] vrf_op3_ren_i,
    input wire vrf_addr_t [W_PORTS_NUM - 1 : 0][2 : 0] vrf_raddr_i,
    input wire word_t [W_PORTS_NUM - 1 : 0][VLANE_NUM - 1 : 0] wdata_i,

    // Complete driver, one address per lane
    input wire vrf_addr_t [VLANE_NUM - 1 : 0] vrf_waddr_complete_i,
    input wire bwen_t [VLANE_NUM - 1 : 0] vrf_bwen_complete_i,

    // Partial drivers 1 .. W-1, address shared by all lanes
    input wire vrf_addr_t [W_PORTS_NUM - 2 : 0] vrf_waddr_partial_i,
    input wire bwen_t [W_PORTS_NUM - 2 : 0][VLANE_NUM - 1 : 0] vrf_bwen_partial_i,

    // From the allocator, already registered
    input wire drv_sel_t [R_PORTS_NUM - 1 : 0] read_port_allocation_i,
    input wire logic [R_PORTS_NUM - 1 : 0] primary_read_data_i,

    lane_vrf_if.ic lanes_o [VLANE_NUM]
);

    typedef struct packed {
        logic [W_PORTS_NUM - 1 : 0] vrf_ren;
        logic [W_PORTS_NUM - 1 : 0] vrf_op3_ren;
        vrf_addr_t [W_PORTS_NUM - 1 : 0][2 : 0] vrf_raddr;
        word_t [W_PORTS_NUM - 1 : 0][VLANE_NUM - 1 : 0] wdata;
        vrf_addr_t [VLANE_NUM - 1 : 0] vrf_waddr_complete;
        bwen_t [VLANE_NUM - 1 : 0] vrf_bwen_complete;
        vrf_addr_t [W_PORTS_NUM - 2 : 0] vrf_waddr_partial;
        bwen_t [W_PORTS_NUM - 2 : 0][VLANE_NUM - 1 : 0] vrf_bwen_partial;
    } input_layer_t;

    input_layer_t input_reg;
    input_layer_t input_next;

    // Read routing is identical in every lane
    logic [R_PORTS_NUM - 1 : 0] rd_ren;
    vrf_addr_t [R_PORTS_NUM - 1 : 0] rd_addr;

    ////////////////////////////////////////
    // Input register

    assign input_next.vrf_ren = vrf_ren_i;
    assign input_next.vrf_op3_ren = vrf_op3_ren_i;
    assign input_next.vrf_raddr = vrf_raddr_i;
    assign input_next.wdata = wdata_i;
    assign input_next.vrf_waddr_complete = vrf_waddr_complete_i;
    assign input_next.vrf_bwen_complete = vrf_bwen_complete_i;
    assign input_next.vrf_waddr_partial = vrf_waddr_partial_i;
    assign input_next.vrf_bwen_partial = vrf_bwen_partial_i;

    // Cleared in reset so that the banks see no write enables
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            input_reg <= '0;
        end else begin
            input_reg <= input_next;
        end
    end

    ////////////////////////////////////////
    // Primary or secondary read source

    for (genvar k = 0; k < R_PORTS_NUM; k++) begin : g_rport
        drv_sel_t owner;
        logic prim_ren;
        logic sec_ren;
        vrf_addr_t prim_addr;
        vrf_addr_t sec_addr;

        assign owner = read_port_allocation_i[k];

        // Ports 2j and 2j+1 carry operands 0 and 1 of driver j
        assign prim_ren = input_reg.vrf_ren[k / 2];
        assign prim_addr = input_reg.vrf_raddr[k / 2][k % 2];

        // Borrowed port reads the third operand of its new owner
        assign sec_ren = input_reg.vrf_ren[owner] & input_reg.vrf_op3_ren[owner];
        assign sec_addr = input_reg.vrf_raddr[owner][2];

        assign rd_ren[k] = primary_read_data_i[k] ? prim_ren : sec_ren;
        assign rd_addr[k] = primary_read_data_i[k] ? prim_addr : sec_addr;
    end

    ////////////////////////////////////////
    // Per-lane bundles

    for (genvar i = 0; i < VLANE_NUM; i++) begin : g_lane
        assign lanes_o[i].ren = rd_ren;
        assign lanes_o[i].raddr = rd_addr;

        for (genvar j = 0; j < W_PORTS_NUM; j++) begin : g_wport
            assign lanes_o[i].wdata[j] = input_reg.wdata[j][i];     // Transpose driver/lane

            if (j == 0) begin : g_complete
                assign lanes_o[i].waddr[j] = input_reg.vrf_waddr_complete[i];
                assign lanes_o[i].bwen[j] = input_reg.vrf_bwen_complete[i];
            end else begin : g_partial
                assign lanes_o[i].waddr[j] = input_reg.vrf_waddr_partial[j - 1];
                assign lanes_o[i].bwen[j] = input_reg.vrf_bwen_partial[j - 1][i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/vrf_bank.sv ====
`default_nettype none

module vrf_bank
    import vlane_pkg::*;
(
    input wire logic clk_i,
    input wire logic rst_i,

    lane_vrf_if.lane vrf_o,

    output word_t [R_PORTS_NUM - 1 : 0] rdata_o,
    output logic [R_PORTS_NUM - 1 : 0] rdata_valid_o
);

    word_t mem [MEM_DEPTH];

    ////////////////////////////////////////
    // Write ports

    // Later ports overwrite earlier ones byte by byte
    always_ff @(posedge clk_i) begin
        for (int p = 0; p < W_PORTS_NUM; p++) begin
            for (int b = 0; b < BYTES_NUM; b++) begin
                if (vrf_o.bwen[p][b]) begin
                    mem[vrf_o.waddr[p]][b * 8 +: 8] <= vrf_o.wdata[p][b * 8 +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////
    // Read ports

    // Sampled on the write edge, so a colliding read sees the old word
    always_ff @(posedge clk_i) begin
        for (int r = 0; r < R_PORTS_NUM; r++) begin
            if (vrf_o.ren[r]) begin
                rdata_o[r] <= mem[vrf_o.raddr[r]];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            rdata_valid_o <= '0;
        end else begin
            rdata_valid_o <= vrf_o.ren;     // One cycle pulse per read
        end
    end

endmodule

`default_nettype wire

// ==== verilog/vlane_top.sv ====
`default_nettype none

module vlane_top
    import vlane_pkg::*;
(
    input wire logic clk_i,
    input wire logic rst_i,

    // Read requests per driver
    input wire logic [W_PORTS_NUM - 1 : 0] vrf_ren_i,
    input wire logic [W_PORTS_NUM - 1 : 0] vrf_op3_ren_i,
    input wire vrf_addr_t [W_PORTS_NUM - 1 : 0][2 : 0] vrf_raddr_i,

    // Write requests
    input wire word_t [W_PORTS_NUM - 1 : 0][VLANE_NUM - 1 : 0] wdata_i,
    input wire vrf_addr_t [VLANE_NUM - 1 : 0] vrf_waddr_complete_i,
    input wire bwen_t [VLANE_NUM - 1 : 0] vrf_bwen_complete_i,
    input wire vrf_addr_t [W_PORTS_NUM - 2 : 0] vrf_waddr_partial_i,
    input wire bwen_t [W_PORTS_NUM - 2 : 0][VLANE_NUM - 1 : 0] vrf_bwen_partial_i,

    // Read data, two edges after the request
    output word_t [VLANE_NUM - 1 : 0][R_PORTS_NUM - 1 : 0] rdata_o,
    output logic [VLANE_NUM - 1 : 0][R_PORTS_NUM - 1 : 0] rdata_valid_o
);

    drv_sel_t [R_PORTS_NUM - 1 : 0] read_port_allocation;
    logic [R_PORTS_NUM - 1 : 0] primary_read_data;

    lane_vrf_if lane_vrf [VLANE_NUM] ();

    read_port_allocator i_read_port_allocator (
        .clk_i                  (clk_i),
        .rst_i                  (rst_i),
        .vrf_ren_i              (vrf_ren_i),
        .vrf_op3_ren_i          (vrf_op3_ren_i),
        .read_port_allocation_o (read_port_allocation),
        .primary_read_data_o    (primary_read_data)
    );

    driver_vlane_interconnect i_driver_vlane_interconnect (
        .clk_i                  (clk_i),
        .rst_i                  (rst_i),
        .vrf_ren_i              (vrf_ren_i),
        .vrf_op3_ren_i          (vrf_op3_ren_i),
        .vrf_raddr_i            (vrf_raddr_i),
        .wdata_i                (wdata_i),
        .vrf_waddr_complete_i   (vrf_waddr_complete_i),
        .vrf_bwen_complete_i    (vrf_bwen_complete_i),
        .vrf_waddr_partial_i    (vrf_waddr_partial_i),
        .vrf_bwen_partial_i     (vrf_bwen_partial_i),
        .read_port_allocation_i (read_port_allocation),
        .primary_read_data_i    (primary_read_data),
        .lanes_o                (lane_vrf)
    );

    ////////////////////////////////////////
    // One bank per lane

    for (genvar i = 0; i < VLANE_NUM; i++) begin : g_bank
        vrf_bank i_vrf_bank (
            .clk_i         (clk_i),
            .rst_i         (rst_i),
            .vrf_o         (lane_vrf[i]),
            .rdata_o       (rdata_o[i]),
            .rdata_valid_o (rdata_valid_o[i])
        );
    end

endmodule

`default_nettype wire

// ==== bench/vlane_assertions.sv ====
`default_nettype none

module vlane_assertions
    import vlane_pkg::*;
(
    input wire logic clk_i,
    input wire logic rst_i,
    input wire logic [W_PORTS_NUM - 1 : 0] vrf_ren_i,
    input wire logic [W_PORTS_NUM - 1 : 0] vrf_op3_ren_i,
    input wire drv_sel_t [R_PORTS_NUM - 1 : 0] read_port_allocation_o,
    input wire logic [R_PORTS_NUM - 1 : 0] primary_read_data_o
);

    logic [W_PORTS_NUM - 1 : 0] op3_req_q;  // Requesters at the allocating edge

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            op3_req_q <= '0;
        end else begin
            op3_req_q <= vrf_ren_i & vrf_op3_ren_i;
        end
    end

    for (genvar k = 0; k < W_PORTS_NUM; k++) begin : g_pair
        a_odd_primary: assert property (@(posedge clk_i) disable iff (!rst_i)
            primary_read_data_o[2 * k + 1])
            else $error("Read port %0d is secondary", 2 * k + 1);

        a_not_own: assert property (@(posedge clk_i) disable iff (!rst_i)
            !primary_read_data_o[2 * k] |-> read_port_allocation_o[2 * k] != drv_sel_t'(k))
            else $error("Read port %0d lent to its own driver", 2 * k);

        a_has_requester: assert property (@(posedge clk_i) disable iff (!rst_i)
            !primary_read_data_o[2 * k] |-> op3_req_q[read_port_allocation_o[2 * k]])
            else $error("Read port %0d lent without a request", 2 * k);
    end

endmodule

bind read_port_allocator vlane_assertions i_vlane_assertions (
    .clk_i                  (clk_i),
    .rst_i                  (rst_i),
    .vrf_ren_i              (vrf_ren_i),
    .vrf_op3_ren_i          (vrf_op3_ren_i),
    .read_port_allocation_o (read_port_allocation_o),
    .primary_read_data_o    (primary_read_data_o)
);

`default_nettype wire

// ==== bench/vlane_tb.sv ====
`default_nettype none

module vlane_tb
    import vlane_pkg::*;
();

    typedef struct packed {
        logic [W_PORTS_NUM - 1 : 0] ren;
        logic [W_PORTS_NUM - 1 : 0] op3;
        vrf_addr_t [W_PORTS_NUM - 1 : 0][2 : 0] raddr;
        vrf_addr_t [VLANE_NUM - 1 : 0] waddr_c;
        vrf_addr_t [W_PORTS_NUM - 2 : 0] waddr_p;
        bwen_t [W_PORTS_NUM - 1 : 0][VLANE_NUM - 1 : 0] bwen;   // Driver 0 is the complete one
        word_t [W_PORTS_NUM - 1 : 0][VLANE_NUM - 1 : 0] wdata;
        logic [R_PORTS_NUM - 1 : 0][3 : 0] owner;               // F when no driver reads
        logic [R_PORTS_NUM - 1 : 0] primary;
    } row_t;

    logic clk_i;
    logic rst_i;
    logic [W_PORTS_NUM - 1 : 0] vrf_ren_i;
    logic [W_PORTS_NUM - 1 : 0] vrf_op3_ren_i;
    vrf_addr_t [W_PORTS_NUM - 1 : 0][2 : 0] vrf_raddr_i;
    word_t [W_PORTS_NUM - 1 : 0][VLANE_NUM - 1 : 0] wdata_i;
    vrf_addr_t [VLANE_NUM - 1 : 0] vrf_waddr_complete_i;
    bwen_t [VLANE_NUM - 1 : 0] vrf_bwen_complete_i;
    vrf_addr_t [W_PORTS_NUM - 2 : 0] vrf_waddr_partial_i;
    bwen_t [W_PORTS_NUM - 2 : 0][VLANE_NUM - 1 : 0] vrf_bwen_partial_i;
    word_t [VLANE_NUM - 1 : 0][R_PORTS_NUM - 1 : 0] rdata_o;
    logic [VLANE_NUM - 1 : 0][R_PORTS_NUM - 1 : 0] rdata_valid_o;

    row_t rows[$];
    word_t shadow [VLANE_NUM][MEM_DEPTH];   // Expected bank contents
    int seed = 92;
    int cycles = 0;
    int cycle_limit = 0;

    vlane_top i_vlane_top (.*);

    always #10 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Test FAILED");
            $fatal(1, "Timeout, run went past %0d cycles", cycle_limit);
        end
    end

    ////////////////////////////////////////
    // Table and drive

    task automatic add_row(
        input logic [W_PORTS_NUM - 1 : 0] ren, op3,
        input int rbase,
        input logic [R_PORTS_NUM - 1 : 0][3 : 0] owner,
        input logic [R_PORTS_NUM - 1 : 0] primary,
        input int wc_base, wc_step, wp1, wp2, wp3,
        input bwen_t [W_PORTS_NUM - 1 : 0][VLANE_NUM - 1 : 0] bw
    );
        row_t r;

        r.ren = ren;
        r.op3 = op3;
        for (int j = 0; j < W_PORTS_NUM; j++) begin
            for (int o = 0; o < 3; o++) begin
                r.raddr[j][o] = vrf_addr_t'((rbase + 3 * j + o) & 15);  // Preloaded words only
            end
        end
        for (int i = 0; i < VLANE_NUM; i++) begin
            r.waddr_c[i] = vrf_addr_t'((wc_base + wc_step * i) & 15);
        end
        r.waddr_p[0] = vrf_addr_t'(wp1 & 15);
        r.waddr_p[1] = vrf_addr_t'(wp2 & 15);
        r.waddr_p[2] = vrf_addr_t'(wp3 & 15);
        r.bwen = bw;
        for (int j = 0; j < W_PORTS_NUM; j++) begin
            for (int i = 0; i < VLANE_NUM; i++) begin
                r.wdata[j][i] = $random(seed);
            end
        end
        r.owner = owner;
        r.primary = primary;
        rows.push_back(r);
    endtask

    task automatic drive_row(input row_t r);
        vrf_ren_i <= r.ren;
        vrf_op3_ren_i <= r.op3;
        vrf_raddr_i <= r.raddr;
        wdata_i <= r.wdata;
        vrf_waddr_complete_i <= r.waddr_c;
        vrf_bwen_complete_i <= r.bwen[0];
        vrf_waddr_partial_i <= r.waddr_p;
        vrf_bwen_partial_i <= r.bwen[W_PORTS_NUM - 1 : 1];
    endtask

    ////////////////////////////////////////
    // Checks and reference model

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("ERROR at %0t: %s read %h, expected %h", $time, what, got, exp);
            $display("Test FAILED");
            $fatal(1, "Read data mismatch");
        end
    endtask

    task automatic check_valid(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERROR at %0t: %s valid is %b, expected %b", $time, what, got, exp);
            $display("Test FAILED");
            $fatal(1, "Read valid mismatch");
        end
    endtask

    task automatic check_row(input row_t r, input int idx);
        logic [3 : 0] owner;
        vrf_addr_t addr;
        string what;

        for (int i = 0; i < VLANE_NUM; i++) begin
            for (int k = 0; k < R_PORTS_NUM; k++) begin
                owner = r.owner[k];
                what = $sformatf("row %0d lane %0d port %0d", idx, i, k);
                check_valid(rdata_valid_o[i][k], owner != 4'hF, what);
                if (owner != 4'hF) begin
                    if (r.primary[k]) begin
                        addr = r.raddr[owner[1 : 0]][k % 2];
                    end else begin
                        addr = r.raddr[owner[1 : 0]][2];    // Borrowed port reads the third operand
                    end
                    check_word(rdata_o[i][k], shadow[i][addr], what);
                end
            end
        end
    endtask

    // Ports applied in ascending order so the highest writer of a byte wins
    task automatic update_shadow(input row_t r);
        vrf_addr_t addr;

        for (int i = 0; i < VLANE_NUM; i++) begin
            for (int p = 0; p < W_PORTS_NUM; p++) begin
                if (p == 0) begin
                    addr = r.waddr_c[i];
                end else begin
                    addr = r.waddr_p[p - 1];
                end
                for (int b = 0; b < BYTES_NUM; b++) begin
                    if (r.bwen[p][i][b]) begin
                        shadow[i][addr][b * 8 +: 8] = r.wdata[p][i][b * 8 +: 8];
                    end
                end
            end
        end
    endtask

    initial begin
        logic [31 : 0] r0;
        logic [31 : 0] r1;
        logic [31 : 0] r2;

        clk_i = 1'b0;
        rst_i = 1'b0;
        drive_row('0);
        vrf_ren_i <= '1;        // Strobes during reset must not reach the banks
        vrf_op3_ren_i <= '1;

        // Full words into addresses 0 to 15 of every lane
        for (int n = 0; n < 4; n++) begin
            add_row(4'h0, 4'h0, 0, '1, 8'hFF, 4 * n, 0, 4 * n + 1, 4 * n + 2, 4 * n + 3, '1);
        end
        // Per-lane complete writes with a shared partial address
        add_row(4'h0, 4'h0, 0, '1, 8'hFF, 0, 1, 4, 5, 6, 64'h6996_3C3C_1248_8421);
        add_row(4'hF, 4'h0, 0, 32'h3322_1100, 8'hFF, 1, 0, 4, 5, 6, 64'h0000_0000_0000_FFFF);
        // Ports 0, 1 and 3 collide on address 5
        add_row(4'hF, 4'h0, 0, 32'h3322_1100, 8'hFF, 5, 0, 5, 7, 5, 64'h0016_0000_00F3_000F);
        add_row(4'hF, 4'h0, 3, 32'h3322_1100, 8'hFF, 0, 0, 0, 0, 0, '0);
        // Third-operand routing
        add_row(4'h5, 4'h5, 0, 32'hF222_F000, 8'hBB, 0, 0, 0, 0, 0, '0);
        add_row(4'hE, 4'hE, 2, 32'h3322_11F1, 8'hFE, 0, 0, 0, 0, 0, '0);
        add_row(4'h7, 4'h9, 5, 32'hF022_1100, 8'hBF, 0, 0, 0, 0, 0, '0);
        add_row(4'h0, 4'hF, 0, '1, 8'hFF, 9, 2, 12, 13, 14, '1);
        add_row(4'hA, 4'hA, 7, 32'h33F3_11F1, 8'hEE, 0, 0, 0, 0, 0, '0);
        repeat (40) begin
            r0 = $random(seed);
            r1 = $random(seed);
            r2 = $random(seed);
            add_row(4'hF, r0[3 : 0], int'(r0[7 : 4]), 32'h3322_1100, 8'hFF, int'(r0[11 : 8]),
                int'(r0[13 : 12]), int'(r0[19 : 16]), int'(r0[23 : 20]), int'(r0[27 : 24]),
                {r1, r2});
        end
        cycle_limit = rows.size() + 20;

        repeat (8) @(posedge clk_i);
        rst_i <= 1'b1;
        drive_row('0);
        @(posedge clk_i);
        @(negedge clk_i);
        for (int i = 0; i < VLANE_NUM; i++) begin
            for (int k = 0; k < R_PORTS_NUM; k++) begin
                check_valid(rdata_valid_o[i][k], 1'b0, "after reset");
            end
        end

        for (int c = 0; c < rows.size() + 2; c++) begin
            @(posedge clk_i);
            if (c < rows.size()) begin
                drive_row(rows[c]);
            end else begin
                drive_row('0);
            end
            @(negedge clk_i);
            if (c >= 2) begin     // Two edges from drive to read data
                check_row(rows[c - 2], c - 2);
                update_shadow(rows[c - 2]);
            end
        end

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
verilog/vlane_pkg.sv
verilog/lane_vrf_if.sv
verilog/read_port_allocator.sv
verilog/driver_vlane_interconnect.sv
verilog/vrf_bank.sv
verilog/vlane_top.sv
bench/vlane_assertions.sv
bench/vlane_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module vlane_tb -f files.f -Mdir obj_dir -o vlane_sim
	./obj_dir/vlane_sim

clean:
	rm -rf obj_dir
